// File: mon_cfg.svh
`ifndef MON_CFG_SVH
`define MON_CFG_SVH

// Word width of the processor write bus, shadow registers and scan register
`define MON_WORD_W 16

// Channel address of the bank register (BB) on the channel bus
`define MON_BB_CHAN 7

// Bit positions inside the monitor control word
`define MON_CTL_MSTP      0 // Stop, holds the timepulse generator
`define MON_CTL_MSTRT     1 // Fresh start request
`define MON_CTL_STEP      2 // Single step pending
`define MON_CTL_STEP_TYPE 3 // Step unit, see mon_pkg::step_type_e
`define MON_CTL_NHALGA    8 // Alarm gate inhibit

`endif

// File: mon_pkg.sv
package mon_pkg;

    // Scan instruction codes, octal as seen by the host
    typedef enum logic [4:0] {
        IR_BYPASS  = 5'o0,  // One-bit bypass path
        IR_CONTROL = 5'o2,  // Control word, read and write
        IR_A       = 5'o20, // Accumulator
        IR_L       = 5'o21, // Lower accumulator
        IR_Q       = 5'o22, // Return address register
        IR_Z       = 5'o23, // Program counter
        IR_BB      = 5'o24, // Both-banks register
        IR_G       = 5'o25, // Memory buffer
        IR_SQ      = 5'o26, // Live instruction bits
        IR_S       = 5'o27, // Address register, 12 bits
        IR_B       = 5'o30, // B buffer register
        IR_X       = 5'o31, // Adder input X, not tracked
        IR_Y       = 5'o32, // Adder input Y, not tracked
        IR_U       = 5'o33  // Adder output, not tracked
    } scan_ir_e;

    // Single step granularity
    typedef enum logic {
        STEP_MCT  = 1'b0, // Ends on the next MT01
        STEP_INST = 1'b1  // Ends on the next new instruction
    } step_type_e;

endpackage

// File: mon_scan_port.sv
`timescale 1ns/100ps
`include "mon_cfg.svh"

module mon_scan_port (
    input  logic                   SIM_CLK,
    input  logic                   reset,
    input  mon_pkg::scan_ir_e      ir_in,     // Current scan instruction
    input  logic                   capture,   // Capture-DR strobe
    input  logic                   shift,     // Shift-DR strobe
    input  logic                   update,    // Update-DR strobe
    input  logic                   tdi,       // Serial data in
    input  logic [`MON_WORD_W-1:0] rd_word,   // Word selected by rd_sel
    output logic                   tdo,       // Serial data out
    output mon_pkg::scan_ir_e      rd_sel,    // Read select toward the register file
    output logic                   ctl_wr,    // Control word write, one cycle
    output logic [`MON_WORD_W-1:0] ctl_wdata  // Control word write data
);

    logic                   bypass_bit;       // Single-bit bypass path
    logic [`MON_WORD_W-1:0] scan_reg;         // Capture and shift register
    logic                   is_bypass;        // Instruction selects bypass path

    assign is_bypass = (ir_in == mon_pkg::IR_BYPASS);

    // Register file reads whatever the host has selected
    assign rd_sel = ir_in;

    // Bypass bit only moves on shift, capture leaves it alone
    always_ff @(posedge SIM_CLK) begin
        if (reset) begin
            bypass_bit <= 1'b0;
        end else if (is_bypass && shift) begin
            bypass_bit <= tdi;                // One stage of delay
        end
    end

    // Data register path for every non-bypass instruction
    always_ff @(posedge SIM_CLK) begin
        if (reset) begin
            scan_reg <= '0;
        end else if (!is_bypass) begin
            if (capture) begin
                scan_reg <= rd_word;          // Snapshot of the selected word
            end else if (shift) begin
                scan_reg <= {tdi, scan_reg[`MON_WORD_W-1:1]}; // LSB leaves first
            end
        end
    end

    // Host samples tdo before each shift strobe
    always_comb begin
        if (is_bypass) begin
            tdo = bypass_bit;
        end else begin
            tdo = scan_reg[0];
        end
    end

    // A finished scan under IR_CONTROL becomes the control write
    assign ctl_wr    = update && (ir_in == mon_pkg::IR_CONTROL);
    assign ctl_wdata = scan_reg;              // Word shifted in by the host

endmodule

// File: mon_reg_file.sv
`timescale 1ns/100ps
`include "mon_cfg.svh"

module mon_reg_file (
    input  logic                   SIM_CLK,
    input  logic                   reset,
    input  logic [`MON_WORD_W-1:0] wl,       // Processor write bus
    input  logic                   wag,      // Write A
    input  logic                   wlg,      // Write L
    input  logic                   wqg,      // Write Q
    input  logic                   wzg,      // Write Z
    input  logic                   wbbeg,    // Write BB, both bank fields
    input  logic                   webg,     // Write EB, erasable bank only
    input  logic                   wfbg,     // Write FB, fixed bank only
    input  logic                   wg,       // Write G
    input  logic                   wsg,      // Write S
    input  logic                   wbg,      // Write B
    input  logic                   wch,      // Channel write, address in S
    input  logic [5:0]             sq_bits,  // SQ16, SQ14..SQ10
    input  logic                   sqext,    // Extended instruction flag
    input  mon_pkg::scan_ir_e      rd_sel,   // Which word to read
    input  logic [`MON_WORD_W-1:0] ctl_word, // Control word from step controller
    output logic [`MON_WORD_W-1:0] rd_word   // Selected word
);

    localparam int S_W = 12;                 // S holds an erasable/fixed address

    logic [`MON_WORD_W-1:0] a_reg;
    logic [`MON_WORD_W-1:0] l_reg;
    logic [`MON_WORD_W-1:0] q_reg;
    logic [`MON_WORD_W-1:0] z_reg;
    logic [`MON_WORD_W-1:0] g_reg;
    logic [`MON_WORD_W-1:0] b_reg;
    logic [`MON_WORD_W-1:0] bb_reg;          // Bits 15, 9:7 and 3 never written
    logic [S_W-1:0]         s_reg;
    logic [`MON_WORD_W-1:0] sq_word;         // Live SQ view
    logic                   bb_chan_hit;     // Channel write aimed at BB

    // Whole-word shadows and S
    always_ff @(posedge SIM_CLK) begin
        if (reset) begin
            a_reg <= '0;
            l_reg <= '0;
            q_reg <= '0;
            z_reg <= '0;
            g_reg <= '0;
            b_reg <= '0;
            s_reg <= '0;
        end else begin
            if (wag) a_reg <= wl;
            if (wlg) l_reg <= wl;
            if (wqg) q_reg <= wl;
            if (wzg) z_reg <= wl;
            if (wg)  g_reg <= wl;
            if (wbg) b_reg <= wl;
            if (wsg) s_reg <= wl[S_W-1:0];   // Upper bus bits dropped
        end
    end

    assign bb_chan_hit = wch && (s_reg == S_W'(`MON_BB_CHAN));

    // Bank bits, later strobe wins on overlapping fields
    always_ff @(posedge SIM_CLK) begin
        if (reset) begin
            bb_reg <= '0;
        end else begin
            if (wbbeg) begin
                bb_reg[14]    <= wl[15];     // Superbank-style top bit
                bb_reg[13:10] <= wl[13:10];  // Fixed bank
                bb_reg[2:0]   <= wl[2:0];    // Erasable bank
            end
            if (webg) begin
                bb_reg[2:0] <= wl[10:8];     // EB sits higher on the bus
            end
            if (wfbg) begin
                bb_reg[14]    <= wl[15];
                bb_reg[13:10] <= wl[13:10];
            end
            if (bb_chan_hit) begin
                bb_reg[6:4] <= wl[6:4];      // Superbank bits via channel 7
            end
        end
    end

    assign sq_word = {sq_bits, 9'b0, sqext}; // SQ16 lands in bit 15

    // Read mux toward the scan port
    always_comb begin
        case (rd_sel)
            mon_pkg::IR_CONTROL: rd_word = ctl_word;
            mon_pkg::IR_A:       rd_word = a_reg;
            mon_pkg::IR_L:       rd_word = l_reg;
            mon_pkg::IR_Q:       rd_word = q_reg;
            mon_pkg::IR_Z:       rd_word = z_reg;
            mon_pkg::IR_BB:      rd_word = bb_reg;
            mon_pkg::IR_G:       rd_word = g_reg;
            mon_pkg::IR_SQ:      rd_word = sq_word;
            mon_pkg::IR_S:       rd_word = {{(`MON_WORD_W-S_W){1'b0}}, s_reg};
            mon_pkg::IR_B:       rd_word = b_reg;
            default:             rd_word = '0; // Bypass, X, Y, U
        endcase
    end

endmodule

// File: mon_step_ctrl.sv
`timescale 1ns/100ps
`include "mon_cfg.svh"

module mon_step_ctrl (
    input  logic                   SIM_CLK,
    input  logic                   reset,
    input  logic                   ctl_wr,    // Control write from scan port
    input  logic [`MON_WORD_W-1:0] ctl_wdata, // New control word
    input  logic                   mt01,      // Timepulse 1, one per memory cycle
    input  logic                   mnisq,     // New instruction in SQ
    output logic [`MON_WORD_W-1:0] ctl_word,  // Current control word
    output logic                   mstp,      // Stop line
    output logic                   mstrt,     // Fresh start line
    output logic                   nhalga     // Alarm inhibit line
);

    logic                 step_req;           // Single step pending
    mon_pkg::step_type_e  step_type;          // MCT or instruction step
    logic                 step_end;           // End event for current step type

    assign step_req  = ctl_word[`MON_CTL_STEP];
    assign step_type = mon_pkg::step_type_e'(ctl_word[`MON_CTL_STEP_TYPE]);

    // Pick the event that closes the step
    always_comb begin
        if (step_type == mon_pkg::STEP_INST) begin
            step_end = mnisq;
        end else begin
            step_end = mt01;
        end
    end

    // Control word, host writes take priority over stepping
    always_ff @(posedge SIM_CLK) begin
        if (reset) begin
            ctl_word <= '0;
        end else if (ctl_wr) begin
            ctl_word <= ctl_wdata;
        end else if (step_req) begin
            if (step_end) begin
                ctl_word[`MON_CTL_STEP] <= 1'b0; // Step done
                ctl_word[`MON_CTL_MSTP] <= 1'b1; // Freeze again
            end else begin
                ctl_word[`MON_CTL_MSTP] <= 1'b0; // Let the processor run
            end
        end
    end

    // Processor control lines come straight from the word
    assign mstp   = ctl_word[`MON_CTL_MSTP];
    assign mstrt  = ctl_word[`MON_CTL_MSTRT];
    assign nhalga = ctl_word[`MON_CTL_NHALGA];

endmodule

// File: mon_top.sv
`timescale 1ns/100ps
`include "mon_cfg.svh"

module mon_top (
    input  logic                   SIM_CLK,
    input  logic                   reset,
    input  mon_pkg::scan_ir_e      ir_in,   // Scan side
    input  logic                   capture,
    input  logic                   shift,
    input  logic                   update,
    input  logic                   tdi,
    output logic                   tdo,
    input  logic [`MON_WORD_W-1:0] wl,      // Processor write bus
    input  logic                   wag,
    input  logic                   wlg,
    input  logic                   wqg,
    input  logic                   wzg,
    input  logic                   wbbeg,
    input  logic                   webg,
    input  logic                   wfbg,
    input  logic                   wg,
    input  logic                   wsg,
    input  logic                   wbg,
    input  logic                   wch,
    input  logic [5:0]             sq_bits, // SQ16, SQ14..SQ10
    input  logic                   sqext,
    input  logic                   mt01,    // Step end events
    input  logic                   mnisq,
    output logic                   mstp,    // Processor control lines
    output logic                   mstrt,
    output logic                   nhalga
);

    mon_pkg::scan_ir_e      rd_sel;         // Scan port to register file
    logic [`MON_WORD_W-1:0] rd_word;        // Register file to scan port
    logic                   ctl_wr;         // Scan port to step controller
    logic [`MON_WORD_W-1:0] ctl_wdata;
    logic [`MON_WORD_W-1:0] ctl_word;       // Step controller to register file

    mon_scan_port mon_scan_port_inst (
        .SIM_CLK   (SIM_CLK),
        .reset     (reset),
        .ir_in     (ir_in),
        .capture   (capture),
        .shift     (shift),
        .update    (update),
        .tdi       (tdi),
        .rd_word   (rd_word),
        .tdo       (tdo),
        .rd_sel    (rd_sel),
        .ctl_wr    (ctl_wr),
        .ctl_wdata (ctl_wdata)
    );

    mon_reg_file mon_reg_file_inst (
        .SIM_CLK  (SIM_CLK),
        .reset    (reset),
        .wl       (wl),
        .wag      (wag),
        .wlg      (wlg),
        .wqg      (wqg),
        .wzg      (wzg),
        .wbbeg    (wbbeg),
        .webg     (webg),
        .wfbg     (wfbg),
        .wg       (wg),
        .wsg      (wsg),
        .wbg      (wbg),
        .wch      (wch),
        .sq_bits  (sq_bits),
        .sqext    (sqext),
        .rd_sel   (rd_sel),
        .ctl_word (ctl_word),
        .rd_word  (rd_word)
    );

    mon_step_ctrl mon_step_ctrl_inst (
        .SIM_CLK   (SIM_CLK),
        .reset     (reset),
        .ctl_wr    (ctl_wr),
        .ctl_wdata (ctl_wdata),
        .mt01      (mt01),
        .mnisq     (mnisq),
        .ctl_word  (ctl_word),
        .mstp      (mstp),
        .mstrt     (mstrt),
        .nhalga    (nhalga)
    );

endmodule

// File: tb_mon_top.sv
`timescale 1ns/100ps
`include "mon_cfg.svh"

module tb_mon_top;

    localparam int TIMEOUT_CYC = 40;          // Bound on every wait loop
    localparam int W_A   = 0;                 // Bit positions of the write strobes in wstb
    localparam int W_L   = 1;
    localparam int W_Q   = 2;
    localparam int W_Z   = 3;
    localparam int W_BBE = 4;
    localparam int W_EB  = 5;
    localparam int W_FB  = 6;
    localparam int W_G   = 7;
    localparam int W_S   = 8;
    localparam int W_B   = 9;
    localparam int W_CH  = 10;
    localparam int WHOLE_W [7] = '{W_A, W_L, W_Q, W_Z, W_G, W_B, W_S};
    localparam mon_pkg::scan_ir_e WHOLE_IR [7] = '{mon_pkg::IR_A, mon_pkg::IR_L,
        mon_pkg::IR_Q, mon_pkg::IR_Z, mon_pkg::IR_G, mon_pkg::IR_B, mon_pkg::IR_S};
    localparam mon_pkg::scan_ir_e ALL_IR [14] = '{mon_pkg::IR_BYPASS, mon_pkg::IR_CONTROL,
        mon_pkg::IR_A, mon_pkg::IR_L, mon_pkg::IR_Q, mon_pkg::IR_Z, mon_pkg::IR_BB,
        mon_pkg::IR_G, mon_pkg::IR_SQ, mon_pkg::IR_S, mon_pkg::IR_B, mon_pkg::IR_X,
        mon_pkg::IR_Y, mon_pkg::IR_U};

    logic                   SIM_CLK;
    logic                   reset;
    mon_pkg::scan_ir_e      ir_in;
    logic                   capture;
    logic                   shift;
    logic                   update;
    logic                   tdi;
    logic                   tdo;
    logic [`MON_WORD_W-1:0] wl;
    logic [10:0]            wstb;             // All processor write strobes
    logic [5:0]             sq_bits;
    logic                   sqext;
    logic                   mt01;
    logic                   mnisq;
    logic                   mstp;
    logic                   mstrt;
    logic                   nhalga;
    logic [15:0]            m_a;              // Reference copy of the shadow registers
    logic [15:0]            m_l;
    logic [15:0]            m_q;
    logic [15:0]            m_z;
    logic [15:0]            m_g;
    logic [15:0]            m_b;
    logic [15:0]            m_bb;
    logic [15:0]            m_ctl;            // Expected control word
    logic [11:0]            m_s;              // S is only 12 bits wide
    string                  name_q [$];       // Pending compares
    logic [15:0]            got_q [$];
    logic [15:0]            exp_q [$];

    mon_top mon_top_inst (
        .*,
        .wag   (wstb[W_A]),
        .wlg   (wstb[W_L]),
        .wqg   (wstb[W_Q]),
        .wzg   (wstb[W_Z]),
        .wbbeg (wstb[W_BBE]),
        .webg  (wstb[W_EB]),
        .wfbg  (wstb[W_FB]),
        .wg    (wstb[W_G]),
        .wsg   (wstb[W_S]),
        .wbg   (wstb[W_B]),
        .wch   (wstb[W_CH])
    );

    always #50 SIM_CLK = ~SIM_CLK;            // 100 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic queue_check(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // Compare process drains everything queued during the last cycle
    always @(posedge SIM_CLK) begin
        while (name_q.size() > 0) begin
            check(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    // Expected shadow contents from the write-strobe rules
    function automatic void apply_write(input int which, input logic [15:0] word);
        case (which)
            W_A: m_a = word;
            W_L: m_l = word;
            W_Q: m_q = word;
            W_Z: m_z = word;
            W_G: m_g = word;
            W_B: m_b = word;
            W_S: m_s = word[11:0];            // Upper bus bits are lost
            W_BBE: begin
                m_bb[14]    = word[15];
                m_bb[13:10] = word[13:10];
                m_bb[2:0]   = word[2:0];
            end
            W_EB: m_bb[2:0] = word[10:8];     // EB field sits at 10:8 on the bus
            W_FB: begin
                m_bb[14]    = word[15];
                m_bb[13:10] = word[13:10];
            end
            W_CH: if (m_s == 12'(`MON_BB_CHAN)) m_bb[6:4] = word[6:4];
            default: ;
        endcase
    endfunction

    function automatic logic [15:0] model_reg(input mon_pkg::scan_ir_e ir);
        logic [15:0] sq_view;
        sq_view        = 16'd0;               // Bits 9:1 always read zero
        sq_view[15]    = sq_bits[5];          // SQ16
        sq_view[14:10] = sq_bits[4:0];        // SQ14..SQ10
        sq_view[0]     = sqext;
        case (ir)
            mon_pkg::IR_CONTROL: return m_ctl;
            mon_pkg::IR_A:       return m_a;
            mon_pkg::IR_L:       return m_l;
            mon_pkg::IR_Q:       return m_q;
            mon_pkg::IR_Z:       return m_z;
            mon_pkg::IR_BB:      return m_bb;
            mon_pkg::IR_G:       return m_g;
            mon_pkg::IR_SQ:      return sq_view;
            mon_pkg::IR_S:       return {4'd0, m_s};
            mon_pkg::IR_B:       return m_b;
            default:             return 16'd0;  // Bypass and the untracked X, Y, U
        endcase
    endfunction

    task automatic bus_write(input int which, input logic [15:0] word);
        @(negedge SIM_CLK);
        wl          = word;
        wstb        = '0;
        wstb[which] = 1'b1;
        apply_write(which, word);
        @(negedge SIM_CLK);
        wstb = '0;
    endtask

    // One capture then 16 shifts with tdo read before each shift
    task automatic scan_read(input mon_pkg::scan_ir_e ir, output logic [15:0] value);
        @(negedge SIM_CLK);
        ir_in   = ir;
        capture = 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(negedge SIM_CLK);
            capture  = 1'b0;
            value[i] = tdo;                   // LSB first
            tdi      = 1'b0;
            shift    = 1'b1;
        end
        @(negedge SIM_CLK);
        shift = 1'b0;
    endtask

    task automatic scan_write(input mon_pkg::scan_ir_e ir, input logic [15:0] value);
        for (int i = 0; i < 16; i++) begin
            @(negedge SIM_CLK);
            ir_in = ir;
            tdi   = value[i];
            shift = 1'b1;
        end
        @(negedge SIM_CLK);
        shift  = 1'b0;
        tdi    = 1'b0;
        update = 1'b1;
        @(negedge SIM_CLK);
        update = 1'b0;                        // Control word already updated here
    endtask

    task automatic read_and_compare(input mon_pkg::scan_ir_e ir);
        logic [15:0] got;
        scan_read(ir, got);
        queue_check(ir.name(), got, model_reg(ir));
    endtask

    task automatic pulse_event(input logic on_mt01);
        @(negedge SIM_CLK);
        mt01  = on_mt01;
        mnisq = !on_mt01;
        @(negedge SIM_CLK);
        mt01  = 1'b0;
        mnisq = 1'b0;
    endtask

    task automatic step_test(input mon_pkg::step_type_e kind);
        logic [15:0] word;
        int          n;
        word = 16'($urandom) & 16'hfff0;
        word[`MON_CTL_MSTP]      = 1'b1;      // Processor stopped when the step is armed
        word[`MON_CTL_STEP]      = 1'b1;
        word[`MON_CTL_STEP_TYPE] = kind;
        scan_write(mon_pkg::IR_CONTROL, word);
        m_ctl = word;
        repeat (3) begin
            @(negedge SIM_CLK);
            queue_check("mstp", 16'(mstp), 16'd0); // Running without an end event
        end
        pulse_event(kind != mon_pkg::STEP_MCT);    // Wrong event for this step type
        queue_check("mstp", 16'(mstp), 16'd0);
        pulse_event(kind == mon_pkg::STEP_MCT);
        n = 0;
        while (mstp !== 1'b1 && n < TIMEOUT_CYC) begin
            @(negedge SIM_CLK);
            n++;
        end
        if (mstp !== 1'b1) abort_run("Timeout waiting for mstp after the step end event");
        m_ctl[`MON_CTL_STEP] = 1'b0;
        m_ctl[`MON_CTL_MSTP] = 1'b1;
        read_and_compare(mon_pkg::IR_CONTROL);
    endtask

    task automatic bypass_check();
        logic [31:0] pattern;
        pattern = $urandom;
        for (int k = 0; k <= 32; k++) begin
            @(negedge SIM_CLK);
            ir_in = mon_pkg::IR_BYPASS;
            if (k > 0) queue_check("tdo", 16'(tdo), 16'(pattern[k-1])); // One shift late
            shift = (k < 32);
            tdi   = (k < 32) ? pattern[k] : 1'b0;
        end
    endtask

    initial begin
        logic [15:0] word;
        int          n;
        void'($urandom(32'h0190_7ae1));
        SIM_CLK = 1'b0;
        reset   = 1'b1;
        ir_in   = mon_pkg::IR_BYPASS;
        capture = 1'b0;
        shift   = 1'b0;
        update  = 1'b0;
        tdi     = 1'b0;
        wl      = '0;
        wstb    = '0;
        sq_bits = '0;
        sqext   = 1'b0;
        mt01    = 1'b0;
        mnisq   = 1'b0;
        {m_a, m_l, m_q, m_z, m_g, m_b, m_bb, m_ctl} = '0;
        m_s     = '0;
        repeat (16) @(negedge SIM_CLK);
        reset = 1'b0;

        for (int k = 0; k < 14; k++) read_and_compare(ALL_IR[k]); // All zero after reset
        queue_check("mstp", 16'(mstp), 16'd0);
        queue_check("mstrt", 16'(mstrt), 16'd0);
        queue_check("nhalga", 16'(nhalga), 16'd0);

        for (int k = 0; k < 7; k++) begin
            repeat (3) begin
                bus_write(WHOLE_W[k], 16'($urandom));
                read_and_compare(WHOLE_IR[k]);
            end
        end

        repeat (4) begin
            bus_write(W_BBE, 16'($urandom));
            read_and_compare(mon_pkg::IR_BB);
            bus_write(W_EB, 16'($urandom));
            read_and_compare(mon_pkg::IR_BB);
            bus_write(W_FB, 16'($urandom));
            read_and_compare(mon_pkg::IR_BB);
        end
        bus_write(W_S, (16'($urandom) & 16'hf000) | 16'(`MON_BB_CHAN)); // Aim at channel 7
        bus_write(W_CH, ~m_bb);                    // Flip the channel bits
        read_and_compare(mon_pkg::IR_BB);
        bus_write(W_S, 16'h0015);
        bus_write(W_CH, ~m_bb);                    // Other channel leaves BB untouched
        read_and_compare(mon_pkg::IR_BB);
        repeat (4) begin
            @(negedge SIM_CLK);
            sq_bits = 6'($urandom);
            sqext   = 1'($urandom);
            read_and_compare(mon_pkg::IR_SQ);
        end

        word = 16'($urandom);
        word[`MON_CTL_STEP] = 1'b0;
        scan_write(mon_pkg::IR_CONTROL, word);
        m_ctl = word;
        queue_check("mstp", 16'(mstp), 16'(word[`MON_CTL_MSTP]));
        queue_check("mstrt", 16'(mstrt), 16'(word[`MON_CTL_MSTRT]));
        queue_check("nhalga", 16'(nhalga), 16'(word[`MON_CTL_NHALGA]));
        read_and_compare(mon_pkg::IR_CONTROL);

        step_test(mon_pkg::STEP_MCT);
        step_test(mon_pkg::STEP_INST);
        bypass_check();

        n = 0;
        while (name_q.size() > 0 && n < TIMEOUT_CYC) begin
            @(negedge SIM_CLK);
            n++;
        end
        if (name_q.size() > 0) begin
            abort_run("Compare queue never drained");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+.
mon_pkg.sv
mon_scan_port.sv
mon_reg_file.sv
mon_step_ctrl.sv
mon_top.sv
tb_mon_top.sv

// File: Makefile
# Verilator build and run for the debug monitor testbench
VERILATOR ?= verilator
TOP       ?= tb_mon_top
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
FLAGS     ?= --binary --timing --timescale 1ns/100ps -j 0
LINTFLAGS ?= --lint-only --timing --timescale 1ns/100ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

# The simulator exits non-zero on $fatal, so make fails with it
run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)
